/* source/rv_pkg.sv */
package rv_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [7:0]  imem_addr_t; // instruction word index
  typedef logic [6:0]  opcode_t;

  localparam xlen_t RESET_PC    = 64'h0;
  localparam int    IMEM_DEPTH  = 256;
  localparam int    DMEM_DEPTH  = 256; // doublewords
  localparam inst_t EBREAK_INST = 32'h0010_0073;

  ////////////////////////////////////////
  // major opcodes
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OPIMM  = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  ////////////////////////////////////////
  // datapath selector codes
  typedef logic [2:0] alu_op_t;
  localparam alu_op_t ALU_ADD   = 3'd0;
  localparam alu_op_t ALU_SUB   = 3'd1;
  localparam alu_op_t ALU_AND   = 3'd2;
  localparam alu_op_t ALU_OR    = 3'd3;
  localparam alu_op_t ALU_XOR   = 3'd4;
  localparam alu_op_t ALU_SLT   = 3'd5;
  localparam alu_op_t ALU_SLTU  = 3'd6;
  localparam alu_op_t ALU_PASSB = 3'd7;

  typedef logic [1:0] src_a_sel_t;
  localparam src_a_sel_t SRC_A_REG  = 2'd0;
  localparam src_a_sel_t SRC_A_PC   = 2'd1;
  localparam src_a_sel_t SRC_A_ZERO = 2'd2;

  typedef logic [1:0] src_b_sel_t;
  localparam src_b_sel_t SRC_B_REG  = 2'd0;
  localparam src_b_sel_t SRC_B_IMM  = 2'd1;
  localparam src_b_sel_t SRC_B_FOUR = 2'd2;

  typedef logic [1:0] wb_sel_t;
  localparam wb_sel_t WB_ALU = 2'd0;
  localparam wb_sel_t WB_MEM = 2'd1;
  localparam wb_sel_t WB_PC4 = 2'd2;

  typedef logic [1:0] pc_sel_t;
  localparam pc_sel_t PC_SEQ    = 2'd0;
  localparam pc_sel_t PC_BRANCH = 2'd1;
  localparam pc_sel_t PC_JALR   = 2'd2;

  // same encoding as funct3[1:0] of loads and stores
  typedef logic [1:0] mem_size_t;
  localparam mem_size_t MEM_BYTE   = 2'd0;
  localparam mem_size_t MEM_WORD   = 2'd2;
  localparam mem_size_t MEM_DOUBLE = 2'd3;

  typedef struct packed {
    alu_op_t    alu_op;
    src_a_sel_t src_a_sel;
    src_b_sel_t src_b_sel;
    wb_sel_t    wb_sel;
    pc_sel_t    pc_sel;
    logic       reg_wen;
    logic       mem_wen;
    mem_size_t  mem_size;
    logic       mem_unsigned;
    logic       branch_ne;     // bne instead of beq
    logic       halt;
  } ctrl_t;

endpackage

/* source/pc_unit.sv */
`timescale 1ns/1ns

module pc_unit (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             halt_i,
  input  rv_pkg::pc_sel_t  pc_sel_i,
  input  logic             taken_i,
  input  rv_pkg::xlen_t    imm_i,
  input  rv_pkg::xlen_t    jalr_target_i,
  output rv_pkg::xlen_t    pc_o,
  output rv_pkg::xlen_t    pc_plus4_o
);

  rv_pkg::xlen_t pc_q;
  rv_pkg::xlen_t pc_next;
  rv_pkg::xlen_t branch_target;
  logic          halted_q; // sticky once ebreak is seen

  assign pc_plus4_o    = pc_q + 64'd4;
  assign branch_target = pc_q + imm_i;

  always_comb begin
    case (pc_sel_i)
      rv_pkg::PC_BRANCH: pc_next = taken_i ? branch_target : pc_plus4_o;
      rv_pkg::PC_JALR:   pc_next = {jalr_target_i[63:1], 1'b0};
      default:           pc_next = pc_plus4_o;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q     <= rv_pkg::RESET_PC;
      halted_q <= 1'b0;
    end else begin
      halted_q <= halted_q | halt_i;
      if (!(halt_i || halted_q)) pc_q <= pc_next; // frozen on ebreak
    end
  end

  assign pc_o = pc_q;

endmodule

/* source/inst_mem.sv */
`timescale 1ns/1ns

module inst_mem (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               we_i,
  input  rv_pkg::imem_addr_t waddr_i,
  input  rv_pkg::inst_t      wdata_i,
  input  rv_pkg::xlen_t      pc_i,
  output rv_pkg::inst_t      inst_o
);

  rv_pkg::inst_t      mem_q [rv_pkg::IMEM_DEPTH];
  rv_pkg::imem_addr_t raddr;

  assign raddr = rv_pkg::imem_addr_t'(pc_i[9:2]); // word aligned fetch

  // program load port, only open while the core is held in reset
  always_ff @(posedge clk) begin
    if (!rst_n_i && we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  assign inst_o = mem_q[raddr];

endmodule

/* source/inst_decode.sv */
`timescale 1ns/1ns

module inst_decode (
  input  rv_pkg::inst_t     inst_i,
  output rv_pkg::reg_addr_t rs1_o,
  output rv_pkg::reg_addr_t rs2_o,
  output rv_pkg::reg_addr_t rd_o,
  output rv_pkg::xlen_t     imm_o,
  output rv_pkg::ctrl_t     ctrl_o
);

  rv_pkg::opcode_t opcode;
  logic [2:0]      funct3;
  rv_pkg::xlen_t   imm_i_type;
  rv_pkg::xlen_t   imm_s_type;
  rv_pkg::xlen_t   imm_b_type;
  rv_pkg::xlen_t   imm_u_type;
  rv_pkg::xlen_t   imm_j_type;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign rd_o   = inst_i[11:7];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];

  ////////////////////////////////////////
  // immediates, all sign extended
  assign imm_i_type = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_type = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b_type = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                       inst_i[11:8], 1'b0};
  assign imm_u_type = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j_type = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                       inst_i[30:21], 1'b0};

  ////////////////////////////////////////
  // control
  always_comb begin
    ctrl_o              = '0;             // no-op unless matched below
    ctrl_o.alu_op       = rv_pkg::ALU_ADD;
    ctrl_o.src_a_sel    = rv_pkg::SRC_A_ZERO;
    ctrl_o.src_b_sel    = rv_pkg::SRC_B_IMM;
    ctrl_o.wb_sel       = rv_pkg::WB_ALU;
    ctrl_o.pc_sel       = rv_pkg::PC_SEQ;
    ctrl_o.mem_size     = rv_pkg::MEM_DOUBLE;
    imm_o               = imm_i_type;
    case (opcode)
      rv_pkg::OPC_LUI: begin
        ctrl_o.alu_op  = rv_pkg::ALU_PASSB;
        ctrl_o.reg_wen = 1'b1;
        imm_o          = imm_u_type;
      end
      rv_pkg::OPC_AUIPC: begin
        ctrl_o.src_a_sel = rv_pkg::SRC_A_PC;
        ctrl_o.reg_wen   = 1'b1;
        imm_o            = imm_u_type;
      end
      rv_pkg::OPC_OPIMM, rv_pkg::OPC_OP: begin
        ctrl_o.src_a_sel = rv_pkg::SRC_A_REG;
        ctrl_o.reg_wen   = 1'b1;
        if (opcode == rv_pkg::OPC_OP) ctrl_o.src_b_sel = rv_pkg::SRC_B_REG;
        case (funct3)
          3'b000: begin
            if (opcode == rv_pkg::OPC_OP && inst_i[30]) ctrl_o.alu_op = rv_pkg::ALU_SUB;
          end
          3'b010: ctrl_o.alu_op = rv_pkg::ALU_SLT;
          3'b011: ctrl_o.alu_op = rv_pkg::ALU_SLTU;
          3'b100: ctrl_o.alu_op = rv_pkg::ALU_XOR;
          3'b110: ctrl_o.alu_op = rv_pkg::ALU_OR;
          3'b111: ctrl_o.alu_op = rv_pkg::ALU_AND;
          default: ctrl_o.reg_wen = 1'b0;     // shifts not supported
        endcase
      end
      rv_pkg::OPC_JAL: begin
        ctrl_o.src_a_sel = rv_pkg::SRC_A_PC;  // alu sees pc + 4 as well
        ctrl_o.src_b_sel = rv_pkg::SRC_B_FOUR;
        ctrl_o.wb_sel    = rv_pkg::WB_PC4;
        ctrl_o.pc_sel    = rv_pkg::PC_BRANCH;
        ctrl_o.reg_wen   = 1'b1;
        imm_o            = imm_j_type;
      end
      rv_pkg::OPC_JALR: begin
        ctrl_o.src_a_sel = rv_pkg::SRC_A_REG;
        ctrl_o.wb_sel    = rv_pkg::WB_PC4;
        ctrl_o.pc_sel    = rv_pkg::PC_JALR;
        ctrl_o.reg_wen   = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        imm_o = imm_b_type;
        if (funct3[2:1] == 2'b00) begin       // beq / bne only
          ctrl_o.src_a_sel = rv_pkg::SRC_A_REG;
          ctrl_o.src_b_sel = rv_pkg::SRC_B_REG;
          ctrl_o.alu_op    = rv_pkg::ALU_SUB;
          ctrl_o.pc_sel    = rv_pkg::PC_BRANCH;
          ctrl_o.branch_ne = funct3[0];
        end
      end
      rv_pkg::OPC_LOAD: begin
        ctrl_o.src_a_sel    = rv_pkg::SRC_A_REG;
        ctrl_o.wb_sel       = rv_pkg::WB_MEM;
        ctrl_o.mem_size     = funct3[1:0];
        ctrl_o.mem_unsigned = funct3[2];
        case (funct3)
          3'b000, 3'b100, 3'b010, 3'b110, 3'b011: ctrl_o.reg_wen = 1'b1;
          default: ctrl_o.reg_wen = 1'b0;
        endcase
      end
      rv_pkg::OPC_STORE: begin
        ctrl_o.src_a_sel = rv_pkg::SRC_A_REG;
        ctrl_o.mem_size  = funct3[1:0];
        imm_o            = imm_s_type;
        case (funct3)
          3'b000, 3'b010, 3'b011: ctrl_o.mem_wen = 1'b1;
          default: ctrl_o.mem_wen = 1'b0;
        endcase
      end
      rv_pkg::OPC_SYSTEM: ctrl_o.halt = (inst_i == rv_pkg::EBREAK_INST);
      default: ;
    endcase
  end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              wen_i,
  input  rv_pkg::reg_addr_t waddr_i,
  input  rv_pkg::xlen_t     wdata_i,
  input  rv_pkg::reg_addr_t raddr1_i,
  input  rv_pkg::reg_addr_t raddr2_i,
  output rv_pkg::xlen_t     rdata1_o,
  output rv_pkg::xlen_t     rdata2_o,
  output rv_pkg::xlen_t     a0_o
);

  rv_pkg::xlen_t regs_q [32];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wen_i && (waddr_i != 5'd0)) begin // x0 stays zero
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];
  assign a0_o     = regs_q[10];

endmodule

/* source/execute.sv */
`timescale 1ns/1ns

module execute (
  input  rv_pkg::ctrl_t ctrl_i,
  input  rv_pkg::xlen_t rs1_data_i,
  input  rv_pkg::xlen_t rs2_data_i,
  input  rv_pkg::xlen_t pc_i,
  input  rv_pkg::xlen_t imm_i,
  output rv_pkg::xlen_t alu_result_o,
  output logic          taken_o
);

  rv_pkg::xlen_t op_a;
  rv_pkg::xlen_t op_b;
  logic          regs_equal;

  ////////////////////////////////////////
  // operand select
  always_comb begin
    case (ctrl_i.src_a_sel)
      rv_pkg::SRC_A_PC:   op_a = pc_i;
      rv_pkg::SRC_A_ZERO: op_a = '0;
      default:            op_a = rs1_data_i;
    endcase
    case (ctrl_i.src_b_sel)
      rv_pkg::SRC_B_IMM:  op_b = imm_i;
      rv_pkg::SRC_B_FOUR: op_b = 64'd4;
      default:            op_b = rs2_data_i;
    endcase
  end

  always_comb begin
    case (ctrl_i.alu_op)
      rv_pkg::ALU_SUB:   alu_result_o = op_a - op_b;
      rv_pkg::ALU_AND:   alu_result_o = op_a & op_b;
      rv_pkg::ALU_OR:    alu_result_o = op_a | op_b;
      rv_pkg::ALU_XOR:   alu_result_o = op_a ^ op_b;
      rv_pkg::ALU_SLT:   alu_result_o = {63'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU:  alu_result_o = {63'b0, op_a < op_b};
      rv_pkg::ALU_PASSB: alu_result_o = op_b;
      default:           alu_result_o = op_a + op_b;
    endcase
  end

  ////////////////////////////////////////
  // branch condition
  assign regs_equal = (rs1_data_i == rs2_data_i);

  // a linking PC_BRANCH op is jal, always taken
  assign taken_o = (ctrl_i.pc_sel == rv_pkg::PC_BRANCH) &&
                   ((ctrl_i.wb_sel == rv_pkg::WB_PC4) || (regs_equal ^ ctrl_i.branch_ne));

endmodule

/* source/data_mem.sv */
`timescale 1ns/1ns

module data_mem (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              wen_i,
  input  rv_pkg::mem_size_t size_i,
  input  rv_pkg::xlen_t     addr_i,
  input  rv_pkg::xlen_t     wdata_i,
  output rv_pkg::xlen_t     rdata_o
);

  rv_pkg::xlen_t mem_q [rv_pkg::DMEM_DEPTH];
  logic [7:0]    idx;
  logic [7:0]    byte_en;
  rv_pkg::xlen_t wdata_lanes; // store data copied into every lane

  assign idx = addr_i[10:3];

  always_comb begin
    case (size_i)
      rv_pkg::MEM_BYTE: begin
        byte_en     = 8'h01 << addr_i[2:0];
        wdata_lanes = {8{wdata_i[7:0]}};
      end
      rv_pkg::MEM_WORD: begin
        byte_en     = 8'h0f << {addr_i[2], 2'b00};
        wdata_lanes = {2{wdata_i[31:0]}};
      end
      default: begin
        byte_en     = 8'hff;
        wdata_lanes = wdata_i;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < rv_pkg::DMEM_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wen_i) begin
      for (int b = 0; b < 8; b++) begin
        if (byte_en[b]) mem_q[idx][b*8 +: 8] <= wdata_lanes[b*8 +: 8];
      end
    end
  end

  assign rdata_o = mem_q[idx];

endmodule

/* source/write_back.sv */
`timescale 1ns/1ns

module write_back (
  input  rv_pkg::ctrl_t ctrl_i,
  input  logic [2:0]    addr_low_i,
  input  rv_pkg::xlen_t mem_rdata_i,
  input  rv_pkg::xlen_t alu_result_i,
  input  rv_pkg::xlen_t pc_plus4_i,
  output rv_pkg::xlen_t wdata_o
);

  logic [7:0]    ld_byte;
  logic [31:0]   ld_word;
  rv_pkg::xlen_t load_val;

  assign ld_byte = mem_rdata_i[{addr_low_i, 3'b000} +: 8];
  assign ld_word = mem_rdata_i[{addr_low_i[2], 5'b00000} +: 32];

  always_comb begin
    case (ctrl_i.mem_size)
      rv_pkg::MEM_BYTE: load_val = ctrl_i.mem_unsigned ? {56'b0, ld_byte}
                                                       : {{56{ld_byte[7]}}, ld_byte};
      rv_pkg::MEM_WORD: load_val = ctrl_i.mem_unsigned ? {32'b0, ld_word}
                                                       : {{32{ld_word[31]}}, ld_word};
      default:          load_val = mem_rdata_i;
    endcase
  end

  always_comb begin
    case (ctrl_i.wb_sel)
      rv_pkg::WB_MEM: wdata_o = load_val;
      rv_pkg::WB_PC4: wdata_o = pc_plus4_i; // link value
      default:        wdata_o = alu_result_i;
    endcase
  end

endmodule

/* source/npc_top.sv */
`timescale 1ns/1ns

module npc_top (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               imem_we_i,
  input  rv_pkg::imem_addr_t imem_addr_i,
  input  rv_pkg::inst_t      imem_wdata_i,
  output rv_pkg::xlen_t      pc_o,
  output logic               halt_o,
  output rv_pkg::xlen_t      a0_o
);

  rv_pkg::xlen_t     pc;
  rv_pkg::xlen_t     pc_plus4;
  rv_pkg::inst_t     inst;
  rv_pkg::reg_addr_t rs1, rs2, rd;
  rv_pkg::xlen_t     imm;
  rv_pkg::ctrl_t     ctrl;
  rv_pkg::xlen_t     rs1_data, rs2_data;
  rv_pkg::xlen_t     alu_result;
  logic              taken;
  rv_pkg::xlen_t     mem_rdata;
  rv_pkg::xlen_t     wb_data;
  logic              reg_wen;
  logic              mem_wen;

  ////////////////////////////////////////
  // nothing retires on the ebreak cycle
  assign reg_wen = ctrl.reg_wen & ~ctrl.halt;
  assign mem_wen = ctrl.mem_wen & ~ctrl.halt;
  assign halt_o  = ctrl.halt;
  assign pc_o    = pc;

  ////////////////////////////////////////
  pc_unit u_pc (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .halt_i        (ctrl.halt),
    .pc_sel_i      (ctrl.pc_sel),
    .taken_i       (taken),
    .imm_i         (imm),
    .jalr_target_i (alu_result),
    .pc_o          (pc),
    .pc_plus4_o    (pc_plus4)
  );

  inst_mem u_imem (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .we_i    (imem_we_i),
    .waddr_i (imem_addr_i),
    .wdata_i (imem_wdata_i),
    .pc_i    (pc),
    .inst_o  (inst)
  );

  inst_decode u_decode (
    .inst_i (inst),
    .rs1_o  (rs1),
    .rs2_o  (rs2),
    .rd_o   (rd),
    .imm_o  (imm),
    .ctrl_o (ctrl)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .wen_i    (reg_wen),
    .waddr_i  (rd),
    .wdata_i  (wb_data),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data),
    .a0_o     (a0_o)
  );

  execute u_exec (
    .ctrl_i       (ctrl),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .pc_i         (pc),
    .imm_i        (imm),
    .alu_result_o (alu_result),
    .taken_o      (taken)
  );

  data_mem u_dmem (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .wen_i   (mem_wen),
    .size_i  (ctrl.mem_size),
    .addr_i  (alu_result),     // effective address
    .wdata_i (rs2_data),
    .rdata_o (mem_rdata)
  );

  write_back u_wb (
    .ctrl_i       (ctrl),
    .addr_low_i   (alu_result[2:0]),
    .mem_rdata_i  (mem_rdata),
    .alu_result_i (alu_result),
    .pc_plus4_i   (pc_plus4),
    .wdata_o      (wb_data)
  );

endmodule

/* testbench/tb_npc.sv */
`timescale 1ns/1ns

module tb_npc;

  localparam int NUM_TESTS   = 6;
  localparam int WORDS       = 12;
  localparam int HALT_LIMIT  = 64;
  localparam int HOLD_CYCLES = 10;
  // reset idle + program load + halt wait + hold check + margin
  localparam int TEST_CYCLES = 3 + WORDS + HALT_LIMIT + HOLD_CYCLES + 2;
  localparam int WATCHDOG_NS = NUM_TESTS * TEST_CYCLES * 10;
  localparam rv_pkg::inst_t EBREAK = 32'h0010_0073;

  typedef struct packed {
    logic [WORDS-1:0][31:0] words;
    rv_pkg::xlen_t          a0;   // expected x10 at halt
    rv_pkg::xlen_t          pc;   // expected address of the ebreak
  } test_t;

  logic               clk;
  logic               rst_n;
  logic               imem_we;
  rv_pkg::imem_addr_t imem_addr;
  rv_pkg::inst_t      imem_wdata;
  rv_pkg::xlen_t      pc;
  logic               halt;
  rv_pkg::xlen_t      a0;

  test_t  tests [NUM_TESTS];
  integer seed;
  int     pass_total;
  int     fail_total;

  npc_top uut (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .imem_we_i    (imem_we),
    .imem_addr_i  (imem_addr),
    .imem_wdata_i (imem_wdata),
    .pc_o         (pc),
    .halt_o       (halt),
    .a0_o         (a0)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // instruction assembly
  function automatic rv_pkg::inst_t imm_op(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, rv_pkg::opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_pkg::inst_t reg_op(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  endfunction

  function automatic rv_pkg::inst_t store_op(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_STORE};
  endfunction

  function automatic rv_pkg::inst_t branch_op(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                              logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
  endfunction

  function automatic rv_pkg::inst_t upper_op(logic [19:0] imm, logic [4:0] rd,
                                             rv_pkg::opcode_t opc);
    return {imm, rd, opc};
  endfunction

  function automatic rv_pkg::inst_t jump_op(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
  endfunction

  function automatic rv_pkg::xlen_t sign_ext12(logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic rv_pkg::xlen_t lui_value(logic [19:0] u);
    return {{32{u[19]}}, u, 12'h000}; // rv64 lui sign extends bit 31
  endfunction

  ////////////////////////////////////////
  // program table
  task automatic build_tests();
    logic [11:0]   ra;
    logic [11:0]   rb;
    logic [11:0]   rc;
    rv_pkg::xlen_t c;
    rv_pkg::xlen_t n;
    rv_pkg::xlen_t d;
    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int i = 0; i < WORDS; i++) tests[t].words[i] = EBREAK;
      tests[t].a0 = '0;
      tests[t].pc = rv_pkg::RESET_PC;
    end

    // addi / add / sub on random immediates
    ra = 12'($random(seed));
    rb = 12'($random(seed));
    rc = 12'($random(seed));
    tests[0].words[0] = imm_op(ra, 0, 3'b000, 5, rv_pkg::OPC_OPIMM);
    tests[0].words[1] = imm_op(rb, 0, 3'b000, 6, rv_pkg::OPC_OPIMM);
    tests[0].words[2] = reg_op(7'h00, 6, 5, 3'b000, 10);
    tests[0].words[3] = imm_op(rc, 0, 3'b000, 7, rv_pkg::OPC_OPIMM);
    tests[0].words[4] = reg_op(7'h20, 7, 10, 3'b000, 10);
    tests[0].a0 = sign_ext12(ra) + sign_ext12(rb) - sign_ext12(rc);
    tests[0].pc = 64'd20;

    // logic and compares of a lui constant against a negative addi value
    c = lui_value(20'h7fabc);
    n = sign_ext12(12'hff0);
    tests[1].words[0]  = upper_op(20'h7fabc, 5, rv_pkg::OPC_LUI);
    tests[1].words[1]  = imm_op(12'hff0, 0, 3'b000, 6, rv_pkg::OPC_OPIMM);
    tests[1].words[2]  = reg_op(7'h00, 6, 5, 3'b111, 10);  // and
    tests[1].words[3]  = reg_op(7'h00, 6, 5, 3'b110, 7);   // or
    tests[1].words[4]  = reg_op(7'h00, 7, 10, 3'b000, 10);
    tests[1].words[5]  = reg_op(7'h00, 6, 5, 3'b100, 7);   // xor
    tests[1].words[6]  = reg_op(7'h00, 7, 10, 3'b000, 10);
    tests[1].words[7]  = reg_op(7'h00, 5, 6, 3'b010, 7);   // slt n < c
    tests[1].words[8]  = reg_op(7'h00, 7, 10, 3'b000, 10);
    tests[1].words[9]  = reg_op(7'h00, 6, 5, 3'b011, 7);   // sltu c < n
    tests[1].words[10] = reg_op(7'h00, 7, 10, 3'b000, 10);
    // n is negative and c positive so both compares give 1
    tests[1].a0 = (c & n) + (c | n) + (c ^ n) + 64'd1 + 64'd1;
    tests[1].pc = 64'd44;

    // sd / sb into one doubleword, then ld, lbu, lb
    c = lui_value(20'h89abd) + sign_ext12(12'hdef);
    n = sign_ext12(12'hfa4);
    d = c;
    d[(69 % 8) * 8 +: 8] = n[7:0];
    tests[2].words[0] = upper_op(20'h89abd, 5, rv_pkg::OPC_LUI);
    tests[2].words[1] = imm_op(12'hdef, 5, 3'b000, 5, rv_pkg::OPC_OPIMM);
    tests[2].words[2] = imm_op(12'hfa4, 0, 3'b000, 6, rv_pkg::OPC_OPIMM);
    tests[2].words[3] = store_op(12'd64, 5, 0, 3'b011);
    tests[2].words[4] = store_op(12'd69, 6, 0, 3'b000);
    tests[2].words[5] = imm_op(12'd64, 0, 3'b011, 7, rv_pkg::OPC_LOAD);
    tests[2].words[6] = imm_op(12'd69, 0, 3'b100, 8, rv_pkg::OPC_LOAD);
    tests[2].words[7] = imm_op(12'd69, 0, 3'b000, 9, rv_pkg::OPC_LOAD);
    tests[2].words[8] = reg_op(7'h00, 8, 7, 3'b000, 10);
    tests[2].words[9] = reg_op(7'h00, 9, 10, 3'b000, 10);
    tests[2].a0 = d + {56'b0, n[7:0]} + {{56{n[7]}}, n[7:0]};
    tests[2].pc = 64'd40;

    // beq taken skips the +100, bne not taken runs the +4
    tests[3].words[0] = imm_op(12'd7, 0, 3'b000, 5, rv_pkg::OPC_OPIMM);
    tests[3].words[1] = imm_op(12'd7, 0, 3'b000, 6, rv_pkg::OPC_OPIMM);
    tests[3].words[2] = imm_op(12'd1, 0, 3'b000, 10, rv_pkg::OPC_OPIMM);
    tests[3].words[3] = branch_op(13'd8, 6, 5, 3'b000);
    tests[3].words[4] = imm_op(12'd100, 10, 3'b000, 10, rv_pkg::OPC_OPIMM);
    tests[3].words[5] = imm_op(12'd2, 10, 3'b000, 10, rv_pkg::OPC_OPIMM);
    tests[3].words[6] = branch_op(13'd8, 6, 5, 3'b001);
    tests[3].words[7] = imm_op(12'd4, 10, 3'b000, 10, rv_pkg::OPC_OPIMM);
    tests[3].words[8] = imm_op(12'd8, 10, 3'b000, 10, rv_pkg::OPC_OPIMM);
    tests[3].a0 = 64'd1 + 64'd2 + 64'd4 + 64'd8;
    tests[3].pc = 64'd36;

    // jal to 12, jalr back to the link address 4
    tests[4].words[0] = jump_op(21'd12, 1);
    tests[4].words[1] = reg_op(7'h00, 11, 1, 3'b000, 10); // link plus x11 from the target
    tests[4].words[3] = imm_op(12'd5, 0, 3'b000, 11, rv_pkg::OPC_OPIMM);
    tests[4].words[4] = imm_op(12'd0, 1, 3'b000, 0, rv_pkg::OPC_JALR);
    tests[4].a0 = 64'd4 + 64'd5;
    tests[4].pc = 64'd8;

    // test 6 is ebreak at the reset address, already in the fill
  endtask

  ////////////////////////////////////////
  task automatic run_test(int t);
    int            cycles;
    int            errors;
    rv_pkg::xlen_t held_pc;
    errors = 0;
    @(negedge clk);
    rst_n   = 1'b0;
    imem_we = 1'b0;
    repeat (3) @(negedge clk);
    for (int i = 0; i < WORDS; i++) begin
      imem_we    = 1'b1;
      imem_addr  = rv_pkg::imem_addr_t'(i);
      imem_wdata = tests[t].words[i];
      @(negedge clk);
    end
    imem_we = 1'b0;
    rst_n   = 1'b1;

    cycles = 0;
    while (!halt && cycles < HALT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end

    if (!halt) begin
      $display("test %0d: core never reached ebreak within %0d cycles", t + 1, HALT_LIMIT);
      errors++;
    end else begin
      if (a0 !== tests[t].a0) begin
        $display("[FAIL] test %0d: a0_o = %h, expected %h", t + 1, a0, tests[t].a0);
        errors++;
      end
      if (pc !== tests[t].pc) begin
        $display("[FAIL] test %0d: pc_o = %h, expected %h", t + 1, pc, tests[t].pc);
        errors++;
      end
      held_pc = pc;
      for (int k = 0; k < HOLD_CYCLES; k++) begin
        @(negedge clk);
        if (!halt) begin
          $display("test %0d: halt_o dropped %0d cycles after ebreak", t + 1, k + 1);
          errors++;
          break;
        end
        if (pc !== held_pc) begin
          $display("[FAIL] test %0d: pc_o = %h, expected %h", t + 1, pc, held_pc);
          errors++;
          break;
        end
      end
    end

    if (errors == 0) begin
      $display("[PASS] test %0d: a0_o = %h, pc_o = %h", t + 1, a0, pc);
      pass_total++;
    end else begin
      $display("test %0d finished with %0d errors", t + 1, errors);
      fail_total++;
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    seed       = 39913;
    pass_total = 0;
    fail_total = 0;
    build_tests();
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    $display("%0d tests: %0d passed, %0d failed", NUM_TESTS, pass_total, fail_total);
    if (fail_total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* files.f */
source/rv_pkg.sv
source/pc_unit.sv
source/inst_mem.sv
source/inst_decode.sv
source/reg_file.sv
source/execute.sv
source/data_mem.sv
source/write_back.sv
source/npc_top.sv
testbench/tb_npc.sv
